// File: src/conv_pkg.sv
package conv_pkg;

    // Datapath widths
    localparam int PIX_W  = 8;
    localparam int TAP_W  = 8;
    localparam int PROD_W = 16;
    localparam int ACC_W  = 32;
    localparam int N_TAPS = 9;          // 3x3 kernel

    // Partial-sum memory, one 16x16 output tile
    localparam int PSUM_DEPTH = 256;
    localparam int PSUM_AW    = 8;

    // AXI4-Lite bus
    localparam int AXI_AW = 12;
    localparam int AXI_DW = 32;

    // Register map, byte addresses
    localparam logic [AXI_AW-1:0] REG_KERNEL_BASE = 12'h000;   // Tap i at base + 4*i
    localparam logic [AXI_AW-1:0] REG_BIAS        = 12'h024;
    localparam logic [AXI_AW-1:0] RESULT_BASE     = 12'h400;   // Up to 0x7FC

    // Response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// File: src/conv_axil_regs.sv
`timescale 1ns/100ps

module conv_axil_regs (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          awvalid,
    output logic                                          awready,
    input  logic [conv_pkg::AXI_AW-1:0]                   awaddr,
    input  logic                                          wvalid,
    output logic                                          wready,
    input  logic [conv_pkg::AXI_DW-1:0]                   wdata,
    input  logic [conv_pkg::AXI_DW/8-1:0]                 wstrb,   // Ignored, full-word writes
    output logic                                          bvalid,
    input  logic                                          bready,
    output logic [1:0]                                    bresp,
    input  logic                                          arvalid,
    output logic                                          arready,
    input  logic [conv_pkg::AXI_AW-1:0]                   araddr,
    output logic                                          rvalid,
    input  logic                                          rready,
    output logic [conv_pkg::AXI_DW-1:0]                   rdata,
    output logic [1:0]                                    rresp,
    input  logic [conv_pkg::ACC_W-1:0]                    rd_data_b,
    output logic [conv_pkg::N_TAPS-1:0][conv_pkg::TAP_W-1:0] kernel_taps,
    output logic [conv_pkg::ACC_W-1:0]                    bias,
    output logic [conv_pkg::PSUM_AW-1:0]                  rd_addr_b
);
    import conv_pkg::*;

    logic              wr_hs;
    logic              ar_hs;
    logic              rd_s1;           // Result address presented to memory
    logic              rd_s2;           // Memory data valid
    logic              rd_result;
    logic [AXI_DW-1:0] rd_reg_data;
    logic [1:0]        rd_resp;
    logic [AXI_DW-1:0] reg_rdata;
    logic [1:0]        reg_rresp;

    function automatic int word_of(input logic [AXI_AW-1:0] a);
        return int'(a[AXI_AW-1:2]);
    endfunction

    function automatic logic tap_hit(input logic [AXI_AW-1:0] a);
        return word_of(a) >= word_of(REG_KERNEL_BASE) &&
               word_of(a) < word_of(REG_KERNEL_BASE) + N_TAPS;
    endfunction

    function automatic logic result_hit(input logic [AXI_AW-1:0] a);
        return word_of(a) >= word_of(RESULT_BASE) &&
               word_of(a) < word_of(RESULT_BASE) + PSUM_DEPTH;
    endfunction

    assign wr_hs = awready && awvalid && wvalid;
    assign ar_hs = arready && arvalid;

    // Write channel, address and data accepted together
    always_ff @(posedge clk) begin
        if (reset) begin
            awready     <= 1'b0;
            wready      <= 1'b0;
            bvalid      <= 1'b0;
            kernel_taps <= '0;
            bias        <= '0;
        end else begin
            awready <= awvalid && wvalid && !awready && !bvalid;
            wready  <= awvalid && wvalid && !awready && !bvalid;
            if (wr_hs) begin
                bvalid <= 1'b1;
                bresp  <= RESP_OKAY;
                if (tap_hit(awaddr)) begin
                    kernel_taps[word_of(awaddr) - word_of(REG_KERNEL_BASE)] <= wdata[TAP_W-1:0];
                end else if (word_of(awaddr) == word_of(REG_BIAS)) begin
                    bias <= wdata;
                end else begin
                    bresp <= RESP_SLVERR;   // Dropped
                end
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // Register side of the read mux
    always_comb begin
        reg_rdata = '0;
        reg_rresp = RESP_OKAY;
        if (tap_hit(araddr)) begin
            reg_rdata = AXI_DW'($signed(kernel_taps[word_of(araddr) - word_of(REG_KERNEL_BASE)]));
        end else if (word_of(araddr) == word_of(REG_BIAS)) begin
            reg_rdata = bias;
        end else if (!result_hit(araddr)) begin
            reg_rresp = RESP_SLVERR;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            arready <= 1'b0;
            rd_s1   <= 1'b0;
            rd_s2   <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rd_s1 && !rd_s2 && !rvalid;
            rd_s1   <= ar_hs;
            rd_s2   <= rd_s1;
            if (rd_s2) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Read payload, captured once and held until rready
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rd_addr_b   <= PSUM_AW'(word_of(araddr) - word_of(RESULT_BASE));
            rd_result   <= result_hit(araddr);
            rd_reg_data <= reg_rdata;
            rd_resp     <= reg_rresp;
        end
        if (rd_s2) begin
            rdata <= rd_result ? rd_data_b : rd_reg_data;
            rresp <= rd_resp;
        end
    end

endmodule

// File: src/conv_mult_stage.sv
`timescale 1ns/100ps

module conv_mult_stage (
    input  logic                                              clk,
    input  logic                                              reset,
    input  logic                                              win_valid,
    input  logic [conv_pkg::N_TAPS-1:0][conv_pkg::PIX_W-1:0]  win_pixels,
    input  logic [conv_pkg::PSUM_AW-1:0]                      win_addr,
    input  logic                                              win_first,
    input  logic [conv_pkg::N_TAPS-1:0][conv_pkg::TAP_W-1:0]  kernel_taps,
    output logic                                              prod_valid,
    output logic [conv_pkg::PSUM_AW-1:0]                      prod_addr,
    output logic                                              prod_first,
    output logic [conv_pkg::N_TAPS-1:0][conv_pkg::PROD_W-1:0] products
);
    import conv_pkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= win_valid;
        end
    end

    // Taps are sampled with the window, so a later tap write
    // does not disturb this product set
    always_ff @(posedge clk) begin
        if (win_valid) begin
            prod_addr  <= win_addr;
            prod_first <= win_first;
            for (int i = 0; i < N_TAPS; i++) begin
                products[i] <= $signed(win_pixels[i]) * $signed(kernel_taps[i]);   // 8x8 signed
            end
        end
    end

endmodule

// File: src/conv_adder_tree.sv
`timescale 1ns/100ps

module conv_adder_tree (
    input  logic                                              clk,
    input  logic                                              reset,
    input  logic                                              prod_valid,
    input  logic [conv_pkg::PSUM_AW-1:0]                      prod_addr,
    input  logic                                              prod_first,
    input  logic [conv_pkg::N_TAPS-1:0][conv_pkg::PROD_W-1:0] products,
    output logic                                              sum_valid,
    output logic [conv_pkg::PSUM_AW-1:0]                      sum_addr,
    output logic                                              sum_first,
    output logic [conv_pkg::ACC_W-1:0]                        dot,
    output logic [conv_pkg::PSUM_AW-1:0]                      rd_addr_a
);
    import conv_pkg::*;

    logic [ACC_W-1:0] ext [N_TAPS];
    logic [ACC_W-1:0] lvl1 [5];
    logic [ACC_W-1:0] lvl2 [3];
    logic [ACC_W-1:0] lvl3 [2];

    // Stored sum comes back from memory in step with sum_valid
    assign rd_addr_a = prod_addr;

    always_comb begin
        for (int i = 0; i < N_TAPS; i++) begin
            ext[i] = {{(ACC_W-PROD_W){products[i][PROD_W-1]}}, products[i]};
        end
        lvl1[0] = ext[0] + ext[1];
        lvl1[1] = ext[2] + ext[3];
        lvl1[2] = ext[4] + ext[5];
        lvl1[3] = ext[6] + ext[7];
        lvl1[4] = ext[8];                  // Odd tap passes down
        lvl2[0] = lvl1[0] + lvl1[1];
        lvl2[1] = lvl1[2] + lvl1[3];
        lvl2[2] = lvl1[4];
        lvl3[0] = lvl2[0] + lvl2[1];
        lvl3[1] = lvl2[2];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= prod_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (prod_valid) begin
            sum_addr  <= prod_addr;
            sum_first <= prod_first;
            dot       <= lvl3[0] + lvl3[1];
        end
    end

endmodule

// File: src/conv_accum_stage.sv
`timescale 1ns/100ps

module conv_accum_stage (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         sum_valid,
    input  logic [conv_pkg::PSUM_AW-1:0] sum_addr,
    input  logic                         sum_first,
    input  logic [conv_pkg::ACC_W-1:0]   dot,
    input  logic [conv_pkg::ACC_W-1:0]   bias,
    input  logic [conv_pkg::ACC_W-1:0]   rd_data_a,
    output logic                         wr_en,
    output logic [conv_pkg::PSUM_AW-1:0] wr_addr,
    output logic [conv_pkg::ACC_W-1:0]   wr_data
);
    import conv_pkg::*;

    // Copy of the write the memory took at the last edge.
    // Port A read at that same edge, so it still returned the old word
    logic               prev_en;
    logic [PSUM_AW-1:0] prev_addr;
    logic [ACC_W-1:0]   prev_data;
    logic [ACC_W-1:0]   stored;
    logic [ACC_W-1:0]   addend;
    logic [ACC_W-1:0]   new_sum;

    always_comb begin
        if (wr_en && wr_addr == sum_addr) begin
            stored = wr_data;              // Newest, not yet in memory
        end else if (prev_en && prev_addr == sum_addr) begin
            stored = prev_data;            // Written at the previous edge
        end else begin
            stored = rd_data_a;
        end
        addend  = sum_first ? bias : stored;
        new_sum = dot + addend;            // Wraps at 32 bits
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_en   <= 1'b0;
            prev_en <= 1'b0;
        end else begin
            wr_en   <= sum_valid;
            prev_en <= wr_en;
        end
    end

    always_ff @(posedge clk) begin
        if (sum_valid) begin
            wr_addr <= sum_addr;
            wr_data <= new_sum;
        end
        prev_addr <= wr_addr;
        prev_data <= wr_data;
    end

endmodule

// File: src/psum_ram.sv
`timescale 1ns/100ps

module psum_ram (
    input  logic                         clk,
    input  logic                         wr_en,
    input  logic [conv_pkg::PSUM_AW-1:0] wr_addr,
    input  logic [conv_pkg::ACC_W-1:0]   wr_data,
    input  logic [conv_pkg::PSUM_AW-1:0] rd_addr_a,
    input  logic [conv_pkg::PSUM_AW-1:0] rd_addr_b,
    output logic [conv_pkg::ACC_W-1:0]   rd_data_a,
    output logic [conv_pkg::ACC_W-1:0]   rd_data_b
);
    import conv_pkg::*;

    logic [ACC_W-1:0] mem [PSUM_DEPTH];

    // Read-first on both ports, a same-edge write shows up a cycle later
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data_a <= mem[rd_addr_a];   // Pipeline port
        rd_data_b <= mem[rd_addr_b];   // Bus readback port
    end

endmodule

// File: src/conv_pe_top.sv
`timescale 1ns/100ps

module conv_pe_top (
    input  logic                                             clk,
    input  logic                                             reset,
    input  logic                                             win_valid,
    input  logic [conv_pkg::N_TAPS-1:0][conv_pkg::PIX_W-1:0] win_pixels,
    input  logic [conv_pkg::PSUM_AW-1:0]                     win_addr,
    input  logic                                             win_first,
    input  logic                                             awvalid,
    output logic                                             awready,
    input  logic [conv_pkg::AXI_AW-1:0]                      awaddr,
    input  logic                                             wvalid,
    output logic                                             wready,
    input  logic [conv_pkg::AXI_DW-1:0]                      wdata,
    input  logic [conv_pkg::AXI_DW/8-1:0]                    wstrb,
    output logic                                             bvalid,
    input  logic                                             bready,
    output logic [1:0]                                       bresp,
    input  logic                                             arvalid,
    output logic                                             arready,
    input  logic [conv_pkg::AXI_AW-1:0]                      araddr,
    output logic                                             rvalid,
    input  logic                                             rready,
    output logic [conv_pkg::AXI_DW-1:0]                      rdata,
    output logic [1:0]                                       rresp
);
    import conv_pkg::*;

    logic [N_TAPS-1:0][TAP_W-1:0]  kernel_taps;
    logic [ACC_W-1:0]              bias;
    logic                          prod_valid;
    logic [PSUM_AW-1:0]            prod_addr;
    logic                          prod_first;
    logic [N_TAPS-1:0][PROD_W-1:0] products;
    logic                          sum_valid;
    logic [PSUM_AW-1:0]            sum_addr;
    logic                          sum_first;
    logic [ACC_W-1:0]              dot;
    logic [PSUM_AW-1:0]            rd_addr_a;
    logic [ACC_W-1:0]              rd_data_a;
    logic [PSUM_AW-1:0]            rd_addr_b;
    logic [ACC_W-1:0]              rd_data_b;
    logic                          wr_en;
    logic [PSUM_AW-1:0]            wr_addr;
    logic [ACC_W-1:0]              wr_data;

    conv_axil_regs u_regs (
        .clk(clk), .reset(reset),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
        .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
        .rd_data_b(rd_data_b), .kernel_taps(kernel_taps), .bias(bias),
        .rd_addr_b(rd_addr_b)
    );

    // Stage 1, products
    conv_mult_stage u_mult (
        .clk(clk), .reset(reset),
        .win_valid(win_valid), .win_pixels(win_pixels),
        .win_addr(win_addr), .win_first(win_first), .kernel_taps(kernel_taps),
        .prod_valid(prod_valid), .prod_addr(prod_addr),
        .prod_first(prod_first), .products(products)
    );

    // Stage 2, sum and partial-sum read
    conv_adder_tree u_tree (
        .clk(clk), .reset(reset),
        .prod_valid(prod_valid), .prod_addr(prod_addr),
        .prod_first(prod_first), .products(products),
        .sum_valid(sum_valid), .sum_addr(sum_addr), .sum_first(sum_first),
        .dot(dot), .rd_addr_a(rd_addr_a)
    );

    // Stage 3, accumulate and write back
    conv_accum_stage u_accum (
        .clk(clk), .reset(reset),
        .sum_valid(sum_valid), .sum_addr(sum_addr), .sum_first(sum_first),
        .dot(dot), .bias(bias), .rd_data_a(rd_data_a),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
    );

    psum_ram u_psum (
        .clk(clk),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b)
    );

endmodule

// File: tests/conv_pe_sva.sv
`timescale 1ns/100ps

module conv_pe_sva (
    input logic                        clk,
    input logic                        reset,
    input logic                        bvalid,
    input logic                        bready,
    input logic                        rvalid,
    input logic                        rready,
    input logic [conv_pkg::AXI_DW-1:0] rdata
);

    int failures = 0;

    // Write response stays up until the master takes it
    bvalid_held: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid)
        else begin
            failures++;
            $error("bvalid dropped before bready");
        end

    rvalid_held: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else begin
            failures++;
            $error("rvalid or rdata changed before rready");
        end

    // Responses come out of reset idle
    idle_after_reset: assert property (@(posedge clk)
        reset |=> !bvalid && !rvalid)
        else begin
            failures++;
            $error("response valid in the cycle after reset");
        end

endmodule

bind conv_axil_regs conv_pe_sva u_sva (
    .clk(clk), .reset(reset), .bvalid(bvalid), .bready(bready),
    .rvalid(rvalid), .rready(rready), .rdata(rdata)
);

// File: tests/conv_pe_tb.sv
`timescale 1ns/100ps

module conv_pe_tb;
    import conv_pkg::*;

    localparam int N_SINGLE   = 16;
    localparam int N_BURSTS   = 4;
    localparam int BURST_LEN  = 24;
    localparam int N_WINDOWS  = N_SINGLE + N_BURSTS * BURST_LEN;
    localparam int N_AXI_OPS  = 62 + N_BURSTS * (10 + BURST_LEN) + N_WINDOWS;
    localparam int MAX_CYCLES = 2 * (N_AXI_OPS * 12 + N_WINDOWS * 4) + 200;

    logic                         clk;
    logic                         reset;
    logic                         win_valid;
    logic [N_TAPS-1:0][PIX_W-1:0] win_pixels;
    logic [PSUM_AW-1:0]           win_addr;
    logic                         win_first;
    logic                         awvalid;
    logic                         awready;
    logic                         wvalid;
    logic                         wready;
    logic                         bvalid;
    logic                         bready;
    logic [AXI_AW-1:0]            awaddr;
    logic [AXI_AW-1:0]            araddr;
    logic [AXI_DW-1:0]            wdata;
    logic [AXI_DW-1:0]            rdata;
    logic [AXI_DW/8-1:0]          wstrb;
    logic [1:0]                   bresp;
    logic [1:0]                   rresp;
    logic                         arvalid;
    logic                         arready;
    logic                         rvalid;
    logic                         rready;

    logic signed [TAP_W-1:0] tap_model [N_TAPS];
    logic [ACC_W-1:0]        bias_model;
    logic [ACC_W-1:0]        psum_model [PSUM_DEPTH];
    bit                      started [PSUM_DEPTH];   // Address has seen a first window
    integer                  seed = 77753;
    int                      errors = 0;
    int                      cycles = 0;

    conv_pe_top UUT (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles with %0d errors", cycles, errors);
            $display("Test failed");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic axi_write(input logic [AXI_AW-1:0] addr, input logic [AXI_DW-1:0] data,
                             output logic [1:0] resp);
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'($random(seed));      // Ignored by the slave
        awvalid = 1'b1;
        wvalid  = 1'b1;
        do @(posedge clk); while (!awready);
        assert (wready) else begin
            errors++;
            $display("CHECK FAILED: wready at %h got %h expected %h", addr, wready, 1'b1);
        end
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        do @(posedge clk); while (!bvalid);
        resp = bresp;
        #1;
        bready = 1'b0;
    endtask

    // Holds rready low for 0 to 3 cycles once rvalid is up
    task automatic axi_read(input logic [AXI_AW-1:0] addr, output logic [AXI_DW-1:0] data,
                            output logic [1:0] resp);
        int hold;
        hold    = $unsigned($random(seed)) % 4;
        araddr  = addr;
        arvalid = 1'b1;
        do @(posedge clk); while (!arready);
        #1;
        arvalid = 1'b0;
        do @(posedge clk); while (!rvalid);
        repeat (hold) @(posedge clk);
        #1;
        rready = 1'b1;
        @(posedge clk);
        data = rdata;
        resp = rresp;
        #1;
        rready = 1'b0;
    endtask

    task automatic expect_write(input logic [AXI_AW-1:0] addr, input logic [AXI_DW-1:0] data,
                                input logic [1:0] exp_resp);
        logic [1:0] resp;
        axi_write(addr, data, resp);
        assert (resp == exp_resp) else begin
            errors++;
            $display("CHECK FAILED: bresp at %h got %h expected %h", addr, resp, exp_resp);
        end
    endtask

    task automatic expect_read(input logic [AXI_AW-1:0] addr, input logic [AXI_DW-1:0] exp_data,
                               input logic [1:0] exp_resp);
        logic [AXI_DW-1:0] got;
        logic [1:0]        resp;
        axi_read(addr, got, resp);
        assert (got == exp_data) else begin
            errors++;
            $display("CHECK FAILED: rdata at %h got %h expected %h", addr, got, exp_data);
        end
        assert (resp == exp_resp) else begin
            errors++;
            $display("CHECK FAILED: rresp at %h got %h expected %h", addr, resp, exp_resp);
        end
    endtask

    function automatic logic [AXI_AW-1:0] tap_addr(input int i);
        return REG_KERNEL_BASE + AXI_AW'(4 * i);
    endfunction

    function automatic logic [AXI_AW-1:0] result_addr(input logic [PSUM_AW-1:0] a);
        return RESULT_BASE + {2'b00, a, 2'b00};
    endfunction

    function automatic logic [AXI_DW-1:0] tap_word(input int i);
        logic signed [AXI_DW-1:0] w;
        w = tap_model[i];                   // Sign extension
        return w;
    endfunction

    function automatic logic [ACC_W-1:0] model_dot(input logic [N_TAPS-1:0][PIX_W-1:0] pix);
        logic signed [ACC_W-1:0] acc;
        logic signed [ACC_W-1:0] p;
        logic signed [ACC_W-1:0] t;
        acc = '0;
        for (int i = 0; i < N_TAPS; i++) begin
            p   = $signed(pix[i]);
            t   = tap_model[i];
            acc = acc + p * t;
        end
        return acc;
    endfunction

    // Random taps and bias, only while the pipeline is idle
    task automatic load_kernel();
        logic [AXI_DW-1:0] val;
        for (int i = 0; i < N_TAPS; i++) begin
            val          = $random(seed);
            tap_model[i] = val[TAP_W-1:0];
            expect_write(tap_addr(i), val, RESP_OKAY);
        end
        val        = $random(seed);
        bias_model = val;
        expect_write(REG_BIAS, val, RESP_OKAY);
    endtask

    task automatic send_window(input logic [PSUM_AW-1:0] addr, input logic first);
        logic [N_TAPS-1:0][PIX_W-1:0] pix;
        logic [ACC_W-1:0]             base;
        for (int i = 0; i < N_TAPS; i++) begin
            pix[i] = PIX_W'($random(seed));
        end
        base             = first ? bias_model : psum_model[addr];
        psum_model[addr] = base + model_dot(pix);       // Wraps at 32 bits
        started[addr]    = 1'b1;
        win_valid  = 1'b1;
        win_pixels = pix;
        win_addr   = addr;
        win_first  = first;
        next_cycle();
        win_valid  = 1'b0;
    endtask

    initial begin
        logic [PSUM_AW-1:0] addr;
        logic [PSUM_AW-1:0] pool_base;
        logic               first;
        logic [PSUM_AW-1:0] burst_q [$];
        bit                 in_burst [PSUM_DEPTH];
        int                 gap;
        clk = 1'b0;
        reset = 1'b1;
        win_valid = 1'b0;
        win_pixels = '0;
        win_addr = '0;
        win_first = 1'b0;
        awvalid = 1'b0;
        awaddr = '0;
        wvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        bready = 1'b0;
        arvalid = 1'b0;
        araddr = '0;
        rready = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        assert (!bvalid) else begin
            errors++;
            $display("CHECK FAILED: bvalid after reset got %h expected %h", bvalid, 1'b0);
        end
        assert (!rvalid) else begin
            errors++;
            $display("CHECK FAILED: rvalid after reset got %h expected %h", rvalid, 1'b0);
        end
        for (int i = 0; i < N_TAPS; i++) expect_read(tap_addr(i), '0, RESP_OKAY);
        expect_read(REG_BIAS, '0, RESP_OKAY);

        // Register map and unmapped addresses
        load_kernel();
        for (int i = 0; i < N_TAPS; i++) expect_read(tap_addr(i), tap_word(i), RESP_OKAY);
        expect_read(REG_BIAS, bias_model, RESP_OKAY);
        expect_write(12'h028, 32'hdead_beef, RESP_SLVERR);
        expect_write(12'h3fc, 32'h1234_5678, RESP_SLVERR);
        expect_write(12'h800, 32'hcafe_f00d, RESP_SLVERR);
        expect_read(12'h028, '0, RESP_SLVERR);
        expect_read(12'h3fc, '0, RESP_SLVERR);
        expect_read(12'hffc, '0, RESP_SLVERR);
        expect_read(REG_BIAS, bias_model, RESP_OKAY);      // Dropped writes left it alone
        expect_read(tap_addr(N_TAPS - 1), tap_word(N_TAPS - 1), RESP_OKAY);

        // Single windows at distinct addresses
        load_kernel();
        for (int i = 0; i < N_SINGLE; i++) send_window(PSUM_AW'(i * 13 + 5), 1'b1);
        repeat (4) next_cycle();
        for (int i = 0; i < N_SINGLE; i++) begin
            addr = PSUM_AW'(i * 13 + 5);
            expect_read(result_addr(addr), psum_model[addr], RESP_OKAY);
        end

        // Channel accumulation bursts over a small address pool
        for (int b = 0; b < N_BURSTS; b++) begin
            load_kernel();
            burst_q.delete();
            foreach (in_burst[a]) in_burst[a] = 1'b0;
            pool_base = PSUM_AW'($random(seed));
            addr      = pool_base;
            for (int k = 0; k < BURST_LEN; k++) begin
                if (k == 0 || $random(seed) % 2 == 0) begin
                    addr = pool_base + PSUM_AW'($unsigned($random(seed)) % 6);
                end
                first = !started[addr] || ($unsigned($random(seed)) % 5 == 0);
                if (!in_burst[addr]) burst_q.push_back(addr);
                in_burst[addr] = 1'b1;
                send_window(addr, first);
                gap = $unsigned($random(seed)) % 5;
                if (gap >= 3) repeat (gap - 2) next_cycle();
            end
            repeat (4) next_cycle();
            foreach (burst_q[q]) begin
                expect_read(result_addr(burst_q[q]), psum_model[burst_q[q]], RESP_OKAY);
            end
        end

        // Full sweep of every written address under read back-pressure
        for (int a = 0; a < PSUM_DEPTH; a++) begin
            if (started[a]) begin
                expect_read(result_addr(PSUM_AW'(a)), psum_model[a], RESP_OKAY);
            end
        end

        $display("Run finished after %0d cycles with %0d errors and %0d assertion failures",
                 cycles, errors, UUT.u_regs.u_sva.failures);
        if (errors == 0 && UUT.u_regs.u_sva.failures == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: project.f
src/conv_pkg.sv
src/conv_axil_regs.sv
src/conv_mult_stage.sv
src/conv_adder_tree.sv
src/conv_accum_stage.sv
src/psum_ram.sv
src/conv_pe_top.sv
tests/conv_pe_sva.sv
tests/conv_pe_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the conv PE testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module conv_pe_tb \
    -Mdir obj_dir -o conv_pe_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/conv_pe_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    exit 1
fi
exit 0
